// ==== verilog/parameters.svh ====
`ifndef PARAMETERS_SVH
`define PARAMETERS_SVH

`define BYTE_LEN_IN_BITS 8

`endif

// ==== verilog/request_types_pkg.sv ====
package request_types_pkg;

    // field widths of one memory request
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;

    // request kind, carried through to the memory port as is
    typedef enum logic [0:0]
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_opcode_e;

    // which client a request came from
    typedef logic [0:0] source_id_t;

    // 97 bits with the address in the top bits
    typedef struct packed
    {
        logic [ADDR_WIDTH - 1 : 0] addr;
        mem_opcode_e               opcode;
        logic [DATA_WIDTH - 1 : 0] data;
    } mem_request_t;

endpackage

// ==== verilog/queue_config_pkg.sv ====
package queue_config_pkg;

    // backing store of a request queue
    typedef enum logic [0:0]
    {
        storage_flipflop = 1'b0,
        storage_lutram   = 1'b1
    } storage_kind_e;

    // depth stays a power of two so the ring pointers wrap on overflow
    localparam int DEFAULT_QUEUE_DEPTH = 4;

    // entry width when a queue is used on its own
    localparam int DEFAULT_ENTRY_WIDTH = 64;

endpackage

// ==== verilog/dual_port_lutram.sv ====
`include "parameters.svh"

module dual_port_lutram
    import queue_config_pkg::*;
#(
    parameter int ENTRY_WIDTH = DEFAULT_ENTRY_WIDTH,
    parameter int NUM_SET     = DEFAULT_QUEUE_DEPTH,
    localparam int ADDR_BITS  = $clog2(NUM_SET),
    localparam int MASK_WIDTH = (ENTRY_WIDTH + `BYTE_LEN_IN_BITS - 1) / `BYTE_LEN_IN_BITS
)
(
    input  logic                       clk_in,
    input  logic                       reset_in,

    input  logic [MASK_WIDTH - 1 : 0]  write_byte_en,
    input  logic [ADDR_BITS - 1 : 0]   write_addr,
    input  logic [ENTRY_WIDTH - 1 : 0] write_data,

    input  logic [ADDR_BITS - 1 : 0]   read_addr,
    output logic [ENTRY_WIDTH - 1 : 0] read_data
);

    logic [ENTRY_WIDTH - 1 : 0] ram [NUM_SET];
    logic [ENTRY_WIDTH - 1 : 0] bit_mask;

    // spread the byte enables over the bits they cover
    // the top byte is partial when the width is not a byte multiple
    genvar b;
    for (b = 0; b < ENTRY_WIDTH; b = b + 1)
    begin : g_bit_mask
        assign bit_mask[b] = write_byte_en[b / `BYTE_LEN_IN_BITS];
    end

    // no writes land while the owner is held in reset
    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < ENTRY_WIDTH; i++)
        begin
            if (!reset_in && bit_mask[i])
            begin
                ram[write_addr][i] <= write_data[i];
            end
        end
    end

    // write-first: a read of the set being written sees the new bytes
    always_comb
    begin
        if (read_addr == write_addr)
        begin
            read_data = (write_data & bit_mask) | (ram[read_addr] & ~bit_mask);
        end
        else
        begin
            read_data = ram[read_addr];
        end
    end

endmodule

// ==== verilog/fifo_queue.sv ====
`include "parameters.svh"

module fifo_queue
    import queue_config_pkg::*;
#(
    parameter int ENTRY_WIDTH            = DEFAULT_ENTRY_WIDTH,
    parameter int QUEUE_DEPTH            = DEFAULT_QUEUE_DEPTH,
    parameter storage_kind_e STORAGE_KIND = storage_lutram
)
(
    input  logic                       clk_in,
    input  logic                       reset_in,

    input  logic [ENTRY_WIDTH - 1 : 0] request_in,
    input  logic                       request_valid_in,
    output logic                       issue_ack_out,

    output logic [ENTRY_WIDTH - 1 : 0] request_out,
    output logic                       request_valid_out,
    input  logic                       issue_ack_in
);

    localparam int PTR_WIDTH  = $clog2(QUEUE_DEPTH);
    localparam int MASK_WIDTH = (ENTRY_WIDTH + `BYTE_LEN_IN_BITS - 1) / `BYTE_LEN_IN_BITS;

    logic [QUEUE_DEPTH - 1 : 0] entry_valid;
    logic [PTR_WIDTH - 1 : 0]   write_ptr;
    logic [PTR_WIDTH - 1 : 0]   read_ptr;
    logic [PTR_WIDTH - 1 : 0]   next_write_ptr;
    logic [PTR_WIDTH - 1 : 0]   next_read_ptr;
    logic [PTR_WIDTH - 1 : 0]   storage_addr;
    logic [ENTRY_WIDTH - 1 : 0] storage_output;
    logic                       is_full;
    logic                       write_fire;
    logic                       read_fire;
    logic                       bypass;

    // pointers wrap on overflow since the depth is a power of two
    assign next_write_ptr = write_ptr + 1'b1;
    assign next_read_ptr  = read_ptr + 1'b1;

    assign is_full       = &entry_valid;
    assign issue_ack_out = ~is_full;

    assign write_fire = request_valid_in & ~is_full;
    assign read_fire  = request_valid_out & issue_ack_in & entry_valid[read_ptr];

    // an incoming write into an empty queue goes straight to the output register
    assign bypass = write_fire & (write_ptr == read_ptr) & ~entry_valid[read_ptr];

    // look ahead to the next entry once the current one has left
    assign storage_addr = read_fire ? next_read_ptr : read_ptr;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            entry_valid <= '0;
        end
        else
        begin
            if (read_fire)
            begin
                entry_valid[read_ptr] <= 1'b0;
            end
            if (write_fire)
            begin
                entry_valid[write_ptr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_ptr         <= '0;
            read_ptr          <= '0;
            request_valid_out <= 1'b0;
        end
        else
        begin
            if (write_fire)
            begin
                write_ptr <= next_write_ptr;
            end

            // output drops for one cycle after each transfer
            if (read_fire)
            begin
                read_ptr          <= next_read_ptr;
                request_valid_out <= 1'b0;
            end
            else if (entry_valid[read_ptr] || bypass)
            begin
                request_valid_out <= 1'b1;
            end
            else
            begin
                request_valid_out <= 1'b0;
            end
        end
    end

    // the output payload is reloaded from the same entry while it waits
    always_ff @(posedge clk_in)
    begin
        if (!read_fire)
        begin
            if (entry_valid[read_ptr])
            begin
                request_out <= storage_output;
            end
            else if (bypass)
            begin
                request_out <= request_in;
            end
        end
    end

    if (STORAGE_KIND == storage_lutram)
    begin : g_lutram
        dual_port_lutram
        #(
            .ENTRY_WIDTH   (ENTRY_WIDTH),
            .NUM_SET       (QUEUE_DEPTH)
        )
        storage
        (
            .clk_in        (clk_in),
            .reset_in      (reset_in),
            .write_byte_en ({MASK_WIDTH{write_fire}}),
            .write_addr    (write_ptr),
            .write_data    (request_in),
            .read_addr     (storage_addr),
            .read_data     (storage_output)
        );
    end
    else
    begin : g_regfile
        logic [ENTRY_WIDTH - 1 : 0] regfile [QUEUE_DEPTH];

        always_ff @(posedge clk_in)
        begin
            if (write_fire)
            begin
                regfile[write_ptr] <= request_in;
            end
        end

        assign storage_output = regfile[storage_addr];
    end

    // a write never lands on an entry that still waits to leave
    a_no_write_when_full: assert property (@(posedge clk_in) disable iff (reset_in)
        write_fire |-> !entry_valid[write_ptr]);

    a_output_stable: assert property (@(posedge clk_in) disable iff (reset_in)
        request_valid_out && !issue_ack_in |=> request_valid_out && $stable(request_out));

endmodule

// ==== verilog/request_arbiter.sv ====
module request_arbiter
    import request_types_pkg::*;
(
    input  logic         clk_in,
    input  logic         reset_in,

    input  mem_request_t src0_request,
    input  logic         src0_valid,
    output logic         src0_ack,

    input  mem_request_t src1_request,
    input  logic         src1_valid,
    output logic         src1_ack,

    output mem_request_t mem_request,
    output source_id_t   mem_source,
    output logic         mem_valid,
    input  logic         mem_ack
);

    source_id_t rr_priority;
    source_id_t grant_src;
    logic       reg_free;
    logic       pick_src1;
    logic       grant_valid;

    // grants only go out while the output register is empty
    assign reg_free = ~mem_valid;

    // source 1 wins when it asks alone, or when both ask and it holds priority
    assign pick_src1   = src1_valid & (~src0_valid | (rr_priority == source_id_t'(1)));
    assign grant_valid = reg_free & (src0_valid | src1_valid);
    assign grant_src   = source_id_t'(pick_src1);

    assign src0_ack = reg_free & src0_valid & ~pick_src1;
    assign src1_ack = reg_free & pick_src1;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            mem_valid   <= 1'b0;
            rr_priority <= '0;
        end
        else
        begin
            if (grant_valid)
            begin
                mem_valid   <= 1'b1;
                rr_priority <= ~grant_src;
            end
            else if (mem_valid && mem_ack)
            begin
                mem_valid <= 1'b0;
            end
        end
    end

    // capture the granted packet with its source tag
    always_ff @(posedge clk_in)
    begin
        if (grant_valid)
        begin
            mem_request <= pick_src1 ? src1_request : src0_request;
            mem_source  <= grant_src;
        end
    end

    a_single_ack: assert property (@(posedge clk_in) disable iff (reset_in)
        !(src0_ack && src1_ack));

    a_mem_stable: assert property (@(posedge clk_in) disable iff (reset_in)
        mem_valid && !mem_ack |=> mem_valid && $stable(mem_request) && $stable(mem_source));

endmodule

// ==== verilog/mem_request_path.sv ====
module mem_request_path
    import request_types_pkg::*;
    import queue_config_pkg::*;
#(
    parameter int QUEUE_DEPTH             = DEFAULT_QUEUE_DEPTH,
    parameter storage_kind_e STORAGE_KIND = storage_lutram
)
(
    input  logic                      clk_in,
    input  logic                      reset_in,

    input  logic [ADDR_WIDTH - 1 : 0] src0_addr,
    input  mem_opcode_e               src0_opcode,
    input  logic [DATA_WIDTH - 1 : 0] src0_data,
    input  logic                      src0_valid,
    output logic                      src0_ack,

    input  logic [ADDR_WIDTH - 1 : 0] src1_addr,
    input  mem_opcode_e               src1_opcode,
    input  logic [DATA_WIDTH - 1 : 0] src1_data,
    input  logic                      src1_valid,
    output logic                      src1_ack,

    output logic [ADDR_WIDTH - 1 : 0] mem_addr,
    output mem_opcode_e               mem_opcode,
    output logic [DATA_WIDTH - 1 : 0] mem_data,
    output source_id_t                mem_source,
    output logic                      mem_valid,
    input  logic                      mem_ack
);

    localparam int ENTRY_WIDTH = $bits(mem_request_t);

    mem_request_t src0_packet;
    mem_request_t src1_packet;
    mem_request_t q0_request;
    mem_request_t q1_request;
    mem_request_t arb_request;
    logic         q0_valid;
    logic         q1_valid;
    logic         q0_ack;
    logic         q1_ack;

    assign src0_packet = '{addr: src0_addr, opcode: src0_opcode, data: src0_data};
    assign src1_packet = '{addr: src1_addr, opcode: src1_opcode, data: src1_data};

    // one queue per client
    fifo_queue
    #(
        .ENTRY_WIDTH       (ENTRY_WIDTH),
        .QUEUE_DEPTH       (QUEUE_DEPTH),
        .STORAGE_KIND      (STORAGE_KIND)
    )
    queue0
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .request_in        (src0_packet),
        .request_valid_in  (src0_valid),
        .issue_ack_out     (src0_ack),
        .request_out       (q0_request),
        .request_valid_out (q0_valid),
        .issue_ack_in      (q0_ack)
    );

    fifo_queue
    #(
        .ENTRY_WIDTH       (ENTRY_WIDTH),
        .QUEUE_DEPTH       (QUEUE_DEPTH),
        .STORAGE_KIND      (STORAGE_KIND)
    )
    queue1
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .request_in        (src1_packet),
        .request_valid_in  (src1_valid),
        .issue_ack_out     (src1_ack),
        .request_out       (q1_request),
        .request_valid_out (q1_valid),
        .issue_ack_in      (q1_ack)
    );

    request_arbiter arbiter
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .src0_request      (q0_request),
        .src0_valid        (q0_valid),
        .src0_ack          (q0_ack),
        .src1_request      (q1_request),
        .src1_valid        (q1_valid),
        .src1_ack          (q1_ack),
        .mem_request       (arb_request),
        .mem_source        (mem_source),
        .mem_valid         (mem_valid),
        .mem_ack           (mem_ack)
    );

    // unpack the output register onto the memory port
    assign mem_addr   = arb_request.addr;
    assign mem_opcode = arb_request.opcode;
    assign mem_data   = arb_request.data;

endmodule

// ==== tests/tb_mem_request_path.sv ====
module tb_mem_request_path
    import request_types_pkg::*;
    import queue_config_pkg::*;
#(
    parameter int STORAGE_SEL = 1
);

    localparam storage_kind_e KIND = storage_kind_e'(STORAGE_SEL);

    // test lengths in cycles
    localparam int LATENCY_CYCLES = 40;
    localparam int ALT_CYCLES     = 250;
    localparam int BP_CYCLES      = 120;
    localparam int RANDOM_CYCLES  = 3000;
    localparam int DRAIN_CYCLES   = 400;
    localparam int CYCLE_LIMIT    =
        2 * (10 + LATENCY_CYCLES + ALT_CYCLES + BP_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES);

    logic              clk_in;
    logic              reset_in;
    logic [31:0]       src0_addr;
    mem_opcode_e       src0_opcode;
    logic [63:0]       src0_data;
    logic              src0_valid;
    logic              src0_ack;
    logic [31:0]       src1_addr;
    mem_opcode_e       src1_opcode;
    logic [63:0]       src1_data;
    logic              src1_valid;
    logic              src1_ack;
    logic [31:0]       mem_addr;
    mem_opcode_e       mem_opcode;
    logic [63:0]       mem_data;
    source_id_t        mem_source;
    logic              mem_valid;
    logic              mem_ack;

    mem_request_t sb0[$];
    mem_request_t sb1[$];
    mem_request_t front;
    logic [31:0]  rng_state = 32'h71ceacfe;
    int           cycles = 0;
    int           errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           errors_at_start;
    int           edges;
    logic         alt_check = 1'b0;
    logic         alt_seen = 1'b0;
    source_id_t   last_src;

    mem_request_path #(.QUEUE_DEPTH(DEFAULT_QUEUE_DEPTH), .STORAGE_KIND(KIND)) uut (.*);

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        errors++;
        $display("error %s got %h expected %h", name, got, expected);
    endtask

    initial
    begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // the scoreboards are popped by mem_source and pushed on client transfers
    always @(posedge clk_in)
    begin
        if (!reset_in && mem_valid && mem_ack)
        begin
            if (mem_source == 1'b0 ? sb0.size() == 0 : sb1.size() == 0)
            begin
                errors++;
                $display("delivery from source %0d with no packet outstanding", mem_source);
            end
            else
            begin
                front = (mem_source == 1'b0) ? sb0.pop_front() : sb1.pop_front();
                assert (mem_addr == front.addr)
                    else report_mismatch("mem_addr", mem_addr, front.addr);
                assert (mem_opcode == front.opcode)
                    else report_mismatch("mem_opcode", mem_opcode, front.opcode);
                assert (mem_data == front.data)
                    else report_mismatch("mem_data", mem_data, front.data);
            end
            if (alt_check && alt_seen)
            begin
                assert (mem_source != last_src)
                    else report_mismatch("mem_source", mem_source, source_id_t'(~last_src));
            end
            alt_seen <= alt_check;
            last_src <= mem_source;
        end
        if (!reset_in && src0_valid && src0_ack)
        begin
            sb0.push_back(mem_request_t'{addr: src0_addr, opcode: src0_opcode,
                                         data: src0_data});
        end
        if (!reset_in && src1_valid && src1_ack)
        begin
            sb1.push_back(mem_request_t'{addr: src1_addr, opcode: src1_opcode,
                                         data: src1_data});
        end
    end

    a_mem_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        mem_valid && !mem_ack |=> mem_valid && $stable(mem_addr) && $stable(mem_opcode)
            && $stable(mem_data) && $stable(mem_source))
    else
    begin
        errors++;
        $display("mem outputs changed while mem_ack was low");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // mode 0 idle, 1 always valid, 2 random valid
    task automatic pick_request(input int mode, output logic valid, output logic [31:0] addr,
                                output mem_opcode_e op, output logic [63:0] data);
        logic [31:0] r;
        rng_state = xorshift32(rng_state);
        r = rng_state;
        valid = (mode == 1) || (mode == 2 && r[1:0] != 2'b00);
        addr = xorshift32(r ^ 32'h5a5a5a5a);
        op = mem_opcode_e'(r[7]);
        data = {xorshift32(addr), r};
    endtask

    // requests are held until they transfer, then replaced
    task automatic drive_cycles(input int n, input int valid_mode, input int ack_mode);
        logic fired0;
        logic fired1;
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk_in);
            fired0 = src0_valid & src0_ack;
            fired1 = src1_valid & src1_ack;
            @(negedge clk_in);
            if (fired0 || !src0_valid)
                pick_request(valid_mode, src0_valid, src0_addr, src0_opcode, src0_data);
            if (fired1 || !src1_valid)
                pick_request(valid_mode, src1_valid, src1_addr, src1_opcode, src1_data);
            rng_state = xorshift32(rng_state);
            mem_ack = (ack_mode == 1) || (ack_mode == 2 && rng_state[3]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > errors_at_start)
            tests_failed++;
        $display("test %s: %s", name, errors > errors_at_start ? "FAILED" : "ok");
        errors_at_start = errors;
    endtask

    // one write into an idle path with the edges counted until mem_valid
    task automatic single_write(input source_id_t src);
        logic [31:0] addr;
        logic [63:0] data;
        addr = 32'h1000_0000 + 32'(src);
        data = 64'hdead_beef_0000_0000 | 64'(src);
        if (src == 1'b0)
        begin
            src0_addr   = addr;
            src0_opcode = op_write;
            src0_data   = data;
            src0_valid  = 1'b1;
        end
        else
        begin
            src1_addr   = addr;
            src1_opcode = op_read;
            src1_data   = data;
            src1_valid  = 1'b1;
        end
        edges = 0;
        do
        begin
            @(posedge clk_in);
            edges++;
            @(negedge clk_in);
            src0_valid = 1'b0;
            src1_valid = 1'b0;
        end
        while (!mem_valid && edges < 10);
        assert (edges == 2)
            else report_mismatch("latency", edges, 2);
        assert (mem_source == src)
            else report_mismatch("mem_source", mem_source, src);
        mem_ack = 1'b1;
        drive_cycles(2, 0, 1);
        mem_ack = 1'b0;
    endtask

    initial
    begin
        reset_in = 1'b1;
        {src0_addr, src0_data, src0_valid} = '0;
        {src1_addr, src1_data, src1_valid} = '0;
        src0_opcode = op_read;
        src1_opcode = op_read;
        mem_ack = 1'b0;
        errors_at_start = 0;
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;

        assert (!mem_valid)
            else report_mismatch("mem_valid", mem_valid, 0);
        assert (src0_ack)
            else report_mismatch("src0_ack", src0_ack, 1);
        assert (src1_ack)
            else report_mismatch("src1_ack", src1_ack, 1);
        end_test("reset");

        single_write(1'b0);
        single_write(1'b1);
        end_test("latency");

        drive_cycles(30, 1, 1);
        alt_check = 1'b1;
        drive_cycles(ALT_CYCLES - 30, 1, 1);
        alt_check = 1'b0;
        end_test("alternation");

        drive_cycles(40, 1, 0);
        assert (!src0_ack)
            else report_mismatch("src0_ack", src0_ack, 0);
        assert (!src1_ack)
            else report_mismatch("src1_ack", src1_ack, 0);
        drive_cycles(BP_CYCLES - 40, 1, 1);
        end_test("back_pressure");

        drive_cycles(RANDOM_CYCLES, 2, 2);
        end_test("random");

        for (int i = 0; i < DRAIN_CYCLES; i++)
        begin
            if (sb0.size() == 0 && sb1.size() == 0 && !mem_valid && !src0_valid && !src1_valid)
                break;
            drive_cycles(1, 0, 1);
        end
        assert (sb0.size() == 0 && sb1.size() == 0)
        else
        begin
            errors++;
            $display("packets never delivered: %0d from source 0, %0d from source 1",
                     sb0.size(), sb1.size());
        end
        end_test("drain");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/request_types_pkg.sv
verilog/queue_config_pkg.sv
verilog/dual_port_lutram.sv
verilog/fifo_queue.sv
verilog/request_arbiter.sv
verilog/mem_request_path.sv
tests/tb_mem_request_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# storage select: 0 is flip-flop storage, 1 is LUTRAM storage
for sel in 0 1; do
    verilator --binary --timing --assert -f compile.f \
        --top-module tb_mem_request_path -GSTORAGE_SEL=${sel} \
        --Mdir obj_dir_${sel} -o sim
    output=$(./obj_dir_${sel}/sim)
    echo "${output}"
    if ! grep -q "All tests passed" <<< "${output}"; then
        exit 1
    fi
done
